//--- ps2KbPkg.sv
/*
 Shared constants and bundles for the PS/2 keyboard receiver.
 Every design module imports this package, and the testbench
 uses it for register offsets and status bit positions.
 */

package ps2KbPkg;

	// FIFO geometry.
	localparam int FifoDepth = 8;
	localparam int FifoPtrW = 3;

	// System clocks without a PS/2 falling edge before a partial frame is dropped.
	localparam int IdleTimeout = 256;
	localparam int IdleCntW = $clog2(IdleTimeout) + 1;

	// APB register map.
	localparam int ApbAddrW = 12;
	localparam logic [ApbAddrW-1:0] RegData = 12'h000;	// Read pops the FIFO.
	localparam logic [ApbAddrW-1:0] RegStatus = 12'h004;
	localparam logic [ApbAddrW-1:0] RegCtrl = 12'h008;

	// Status register bit positions.
	localparam int StatNotEmpty = 0;
	localparam int StatFull = 1;
	localparam int StatOverflow = 2;	// Sticky, write 1 to clear.
	localparam int StatFrameErr = 3;	// Sticky, write 1 to clear.

	// APB request from the bus master.
	typedef struct packed
	{
		logic sel;
		logic enable;
		logic write;
		logic [ApbAddrW-1:0] addr;
		logic [31:0] wdata;
	} apbReqT;

	// APB response back to the master.
	typedef struct packed
	{
		logic [31:0] rdata;
		logic ready;
		logic slverr;
	} apbRspT;

	/*
	 Result of one received frame. valid pulses for a single cycle,
	 error marks a start, stop or parity failure.
	 */
	typedef struct packed
	{
		logic valid;
		logic error;
		logic [7:0] code;
	} rxFrameT;

endpackage

//--- ps2FrameRx.sv
/*
 PS/2 frame receiver. Synchronizes the keyboard clock and data,
 shifts a bit in on each clock falling edge and checks the 11-bit
 frame. A one-cycle result pulse goes to the FIFO and the registers.
 */

module ps2FrameRx
	import ps2KbPkg::*;
(
	input logic clock,
	input logic rstN_i,
	input logic enable_i,
	input logic ps2Clk_i,
	input logic ps2Data_i,
	output rxFrameT frame_o
);

	logic [2:0] clkSync;	// Two sync stages, then the edge stage.
	logic [1:0] dataSync;
	logic fallEdge;
	logic [10:0] window;
	logic [3:0] bitCnt;
	logic frameDone;
	logic [IdleCntW-1:0] idleCnt;
	logic frameOk;

	assign fallEdge = clkSync[2] & ~clkSync[1];

	// Start low, stop high, data plus parity of odd weight.
	assign frameOk = ~window[0] & window[10] & (^window[9:1]);

	// Lines idle high, so the synchronizers come out of reset high.
	always_ff @(posedge clock)
	begin
		if (!rstN_i)
		begin
			clkSync <= '1;
			dataSync <= '1;
		end
		else
		begin
			clkSync <= {clkSync[1:0], ps2Clk_i};
			dataSync <= {dataSync[0], ps2Data_i};
		end
	end

	// LSB first, so after eleven shifts the start bit sits in bit 0.
	always_ff @(posedge clock)
	begin
		if (fallEdge)
			window <= {dataSync[1], window[10:1]};
	end

	always_ff @(posedge clock)
	begin
		if (!rstN_i || !enable_i)
		begin
			bitCnt <= '0;
			frameDone <= 1'b0;
			idleCnt <= '0;
		end
		else if (fallEdge)
		begin
			idleCnt <= '0;
			if (bitCnt == 4'd10)
			begin
				bitCnt <= '0;
				frameDone <= 1'b1;	// Eleventh bit is in.
			end
			else
			begin
				bitCnt <= bitCnt + 4'd1;
				frameDone <= 1'b0;
			end
		end
		else
		begin
			frameDone <= 1'b0;
			if (bitCnt != 4'd0)
			begin
				// Keyboard went quiet mid-frame, drop what we have.
				if (idleCnt == IdleCntW'(IdleTimeout - 1))
				begin
					bitCnt <= '0;
					idleCnt <= '0;
				end
				else
					idleCnt <= idleCnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rstN_i)
			frame_o <= '0;
		else
		begin
			frame_o.valid <= frameDone & enable_i;
			frame_o.error <= ~frameOk;
			frame_o.code <= window[8:1];
		end
	end

endmodule

//--- scanFifo.sv
/*
 Eight-entry scan code queue between the receiver and the bus.
 Only good frames are written. A good code arriving while full is
 discarded and flagged through dropped_o.
 */

module scanFifo
	import ps2KbPkg::*;
(
	input logic clock,
	input logic rstN_i,
	input rxFrameT frame_i,
	input logic pop_i,
	input logic flush_i,
	output logic [7:0] head_o,
	output logic empty_o,
	output logic full_o,
	output logic dropped_o
);

	logic [7:0] mem [FifoDepth];
	logic [FifoPtrW-1:0] wrPtr;
	logic [FifoPtrW-1:0] rdPtr;
	logic [FifoPtrW:0] count;
	logic push;
	logic doWrite;
	logic doRead;

	assign push = frame_i.valid & ~frame_i.error;
	assign doWrite = push & ~full_o;
	assign doRead = pop_i & ~empty_o;

	assign empty_o = (count == '0);
	assign full_o = (count == (FifoPtrW + 1)'(FifoDepth));
	assign head_o = mem[rdPtr];	// Oldest code.

	always_ff @(posedge clock)
	begin
		if (doWrite)
			mem[wrPtr] <= frame_i.code;
	end

	always_ff @(posedge clock)
	begin
		if (!rstN_i || flush_i)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			dropped_o <= 1'b0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;	// Wraps at the depth.
			if (doRead)
				rdPtr <= rdPtr + 1'b1;

			case ({doWrite, doRead})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase

			dropped_o <= push & full_o;
		end
	end

endmodule

//--- ps2ApbRegs.sv
/*
 APB register block for the keyboard receiver. Offers the data,
 status and control registers, keeps the sticky overflow and frame
 error flags and drives FIFO pop and flush. No wait states.
 */

module ps2ApbRegs
	import ps2KbPkg::*;
(
	input logic clock,
	input logic rstN_i,
	input apbReqT apbReq_i,
	output apbRspT apbRsp_o,
	input rxFrameT frame_i,
	input logic [7:0] head_i,
	input logic empty_i,
	input logic full_i,
	input logic dropped_i,
	output logic pop_o,
	output logic flush_o,
	output logic enable_o
);

	logic access;
	logic rdAcc;
	logic wrAcc;
	logic hitData;
	logic hitStatus;
	logic hitCtrl;
	logic badAddr;
	logic enableQ;
	logic overflow;
	logic frameErr;
	logic [31:0] statusWord;
	logic [31:0] rdWord;

	// Access phase of a two-phase transfer.
	assign access = apbReq_i.sel & apbReq_i.enable;
	assign rdAcc = access & ~apbReq_i.write;
	assign wrAcc = access & apbReq_i.write;

	assign hitData = (apbReq_i.addr == RegData);
	assign hitStatus = (apbReq_i.addr == RegStatus);
	assign hitCtrl = (apbReq_i.addr == RegCtrl);
	assign badAddr = ~(hitData | hitStatus | hitCtrl);

	assign pop_o = rdAcc & hitData & ~empty_i;

	// Only a 1 to 0 transition of the enable bit flushes.
	assign flush_o = wrAcc & hitCtrl & enableQ & ~apbReq_i.wdata[0];
	assign enable_o = enableQ;

	always_comb
	begin
		statusWord = '0;
		statusWord[StatNotEmpty] = ~empty_i;
		statusWord[StatFull] = full_i;
		statusWord[StatOverflow] = overflow;
		statusWord[StatFrameErr] = frameErr;
	end

	always_comb
	begin
		rdWord = '0;
		if (hitData && !empty_i)
			rdWord = {24'd0, head_i};
		else if (hitStatus)
			rdWord = statusWord;
		else if (hitCtrl)
			rdWord = {31'd0, enableQ};
	end

	always_comb
	begin
		apbRsp_o.rdata = rdAcc ? rdWord : '0;
		apbRsp_o.ready = 1'b1;
		// Unknown offsets and writes to the data register are refused.
		apbRsp_o.slverr = access & (badAddr | (apbReq_i.write & hitData));
	end

	always_ff @(posedge clock)
	begin
		if (!rstN_i)
		begin
			enableQ <= 1'b0;
			overflow <= 1'b0;
			frameErr <= 1'b0;
		end
		else
		begin
			if (wrAcc && hitCtrl)
				enableQ <= apbReq_i.wdata[0];

			// A new event wins over a clear in the same cycle.
			if (dropped_i)
				overflow <= 1'b1;
			else if (wrAcc && hitStatus && apbReq_i.wdata[StatOverflow])
				overflow <= 1'b0;

			if (frame_i.valid && frame_i.error)
				frameErr <= 1'b1;
			else if (wrAcc && hitStatus && apbReq_i.wdata[StatFrameErr])
				frameErr <= 1'b0;
		end
	end

endmodule

//--- ps2KbTop.sv
/*
 PS/2 keyboard receiver with an APB register interface.
 Connects the frame receiver, the scan code FIFO and the registers.
 */

module ps2KbTop
	import ps2KbPkg::*;
(
	input logic clock,
	input logic rstN_i,
	input logic ps2Clk_i,
	input logic ps2Data_i,
	input apbReqT apbReq_i,
	output apbRspT apbRsp_o
);

	rxFrameT frame;
	logic [7:0] head;
	logic empty;
	logic full;
	logic dropped;
	logic pop;
	logic flush;
	logic enable;

	ps2FrameRx frameRx
	(
		.clock(clock),
		.rstN_i(rstN_i),
		.enable_i(enable),
		.ps2Clk_i(ps2Clk_i),
		.ps2Data_i(ps2Data_i),
		.frame_o(frame)
	);

	scanFifo fifo
	(
		.clock(clock),
		.rstN_i(rstN_i),
		.frame_i(frame),
		.pop_i(pop),
		.flush_i(flush),
		.head_o(head),
		.empty_o(empty),
		.full_o(full),
		.dropped_o(dropped)
	);

	ps2ApbRegs regs
	(
		.clock(clock),
		.rstN_i(rstN_i),
		.apbReq_i(apbReq_i),
		.apbRsp_o(apbRsp_o),
		.frame_i(frame),
		.head_i(head),
		.empty_i(empty),
		.full_i(full),
		.dropped_i(dropped),
		.pop_o(pop),
		.flush_o(flush),
		.enable_o(enable)
	);

endmodule

//--- ps2KbdModel.sv
/*
 Keyboard side of a PS/2 link for the testbench. sendFrame serializes
 one scan code as start, eight data bits LSB first, odd parity and stop.
 Parity or stop can be corrupted to exercise the frame checks.
 */

module ps2KbdModel
(
	input logic clock,
	output logic ps2Clk_o,
	output logic ps2Data_o
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HalfPeriod = 20;	// System cycles per PS/2 clock phase.
	localparam int IdleCycles = 60;

	// Both lines idle high.
	initial
	begin
		ps2Clk_o <= 1'b1;
		ps2Data_o <= 1'b1;
	end

	task automatic waitCycles(input int n);
		repeat (n) @(posedge clock);
	endtask

	task automatic sendFrame(input logic [7:0] code, input logic badParity,
		input logic badStop);
		logic [10:0] bits;
		bits = {~badStop, (~^code) ^ badParity, code, 1'b0};
		for (int i = 0; i < 11; i++)
		begin
			// Data changes while the clock is high, the host samples on the fall.
			@(posedge clock);
			ps2Data_o <= bits[i];
			waitCycles(HalfPeriod);
			ps2Clk_o <= 1'b0;
			waitCycles(HalfPeriod);
			ps2Clk_o <= 1'b1;
		end
		@(posedge clock);
		ps2Data_o <= 1'b1;
		waitCycles(IdleCycles);
	endtask

endmodule

//--- ps2KbTb.sv
/*
 Testbench for the PS/2 keyboard receiver. A keyboard model sends frames,
 APB tasks read the registers, a queue model predicts each read, and a
 checker process compares. Run through run.sh.
 */

module ps2KbTb
	import ps2KbPkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NumFrames = 24;
	localparam int WatchdogNs = NumFrames * 11 * 40 * 4 + 20000;	// Margin covers idle and APB.

	logic clock = 1'b0;
	logic rstN;
	logic ps2Clk;
	logic ps2Data;
	apbReqT apbReq;
	apbRspT apbRsp;

	logic [7:0] refQ[$];
	logic refEnable = 1'b0;
	logic refOverflow = 1'b0;
	logic refFrameErr = 1'b0;

	string labelQ[$];
	logic [31:0] expQ[$];
	logic [31:0] actQ[$];
	string testName;
	int testErrs = 0;
	int errCount = 0;
	int testsRun = 0;
	int testsFailed = 0;

	always #2 clock = ~clock;

	ps2KbTop UUT
	(
		.clock(clock),
		.rstN_i(rstN),
		.ps2Clk_i(ps2Clk),
		.ps2Data_i(ps2Data),
		.apbReq_i(apbReq),
		.apbRsp_o(apbRsp)
	);

	ps2KbdModel kbd
	(
		.clock(clock),
		.ps2Clk_o(ps2Clk),
		.ps2Data_o(ps2Data)
	);

	// Expected read value, popping the model queue on a data read.
	function automatic logic [31:0] refRead(input logic [ApbAddrW-1:0] addr);
		logic [31:0] value;
		value = 32'd0;
		if (addr == RegData)
		begin
			if (refQ.size() > 0)
				value = {24'd0, refQ.pop_front()};
		end
		else if (addr == RegStatus)
		begin
			value[StatNotEmpty] = (refQ.size() > 0);
			value[StatFull] = (refQ.size() == FifoDepth);
			value[StatOverflow] = refOverflow;
			value[StatFrameErr] = refFrameErr;
		end
		else if (addr == RegCtrl)
			value[0] = refEnable;
		return value;
	endfunction

	function automatic void refWrite(input logic [ApbAddrW-1:0] addr, input logic [31:0] data);
		if (addr == RegCtrl)
		begin
			if (refEnable && !data[0])
				refQ.delete();	// Disable flushes.
			refEnable = data[0];
		end
		else if (addr == RegStatus)
		begin
			if (data[StatOverflow])
				refOverflow = 1'b0;
			if (data[StatFrameErr])
				refFrameErr = 1'b0;
		end
	endfunction

	function automatic void refFrame(input logic [7:0] code, input logic bad);
		if (!refEnable)
			return;
		if (bad)
			refFrameErr = 1'b1;
		else if (refQ.size() < FifoDepth)
			refQ.push_back(code);
		else
			refOverflow = 1'b1;
	endfunction

	function automatic logic expSlverr(input logic write, input logic [ApbAddrW-1:0] addr);
		return !(addr == RegData || addr == RegStatus || addr == RegCtrl)
			|| (write && addr == RegData);
	endfunction

	always @(negedge clock)
	begin
		string label;
		logic [31:0] exp;
		logic [31:0] act;
		while (actQ.size() > 0)
		begin
			label = labelQ.pop_front();
			exp = expQ.pop_front();
			act = actQ.pop_front();
			if (exp !== act)
			begin
				$display("ERR %s expected 0x%08h actual 0x%08h", label, exp, act);
				testErrs++;
				errCount++;
			end
		end
	end

	task automatic waitCycles(input int n);
		repeat (n) @(posedge clock);
	endtask

	task automatic record(input string what, input logic [31:0] exp, input logic [31:0] act);
		labelQ.push_back({testName, ": ", what});
		expQ.push_back(exp);
		actQ.push_back(act);
	endtask

	// Setup phase, then one access phase; ready is sampled there too.
	task automatic apbAccess(input logic write, input logic [ApbAddrW-1:0] addr,
		input logic [31:0] wdata, output apbRspT rsp);
		apbReqT req;
		req.sel = 1'b1;
		req.enable = 1'b0;
		req.write = write;
		req.addr = addr;
		req.wdata = wdata;
		@(posedge clock);
		apbReq <= req;
		@(posedge clock);
		apbReq.enable <= 1'b1;
		@(negedge clock);
		rsp = apbRsp;
		record("ready", 32'd1, {31'd0, rsp.ready});
		record("slverr", {31'd0, expSlverr(write, addr)}, {31'd0, rsp.slverr});
		@(posedge clock);
		apbReq <= '0;
	endtask

	task automatic readCheck(input string what, input logic [ApbAddrW-1:0] addr);
		apbRspT rsp;
		logic [31:0] exp;
		exp = refRead(addr);
		apbAccess(1'b0, addr, 32'd0, rsp);
		record(what, exp, rsp.rdata);
	endtask

	task automatic writeReg(input logic [ApbAddrW-1:0] addr, input logic [31:0] data);
		apbRspT rsp;
		apbAccess(1'b1, addr, data, rsp);
		refWrite(addr, data);
	endtask

	task automatic sendCode(input logic badParity, input logic badStop);
		logic [7:0] code;
		code = 8'($urandom_range(255, 0));
		refFrame(code, badParity | badStop);
		kbd.sendFrame(code, badParity, badStop);
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrs = 0;
	endtask

	task automatic endTest();
		while (actQ.size() > 0)
			@(negedge clock);	// Let the checker drain.
		testsRun++;
		if (testErrs == 0)
			$display("PASS %s", testName);
		else
		begin
			$display("FAIL %s with %0d mismatches", testName, testErrs);
			testsFailed++;
		end
	endtask

	initial
	begin
		#(WatchdogNs);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Done: errors found");
		$finish;
	end

	initial
	begin
		void'($urandom(81124));
		apbReq <= '0;
		rstN <= 1'b0;
		waitCycles(3);
		rstN <= 1'b1;
		waitCycles(2);

		startTest("reset and disable");
		readCheck("status", RegStatus);
		readCheck("ctrl", RegCtrl);
		repeat (2) sendCode(1'b0, 1'b0);
		readCheck("status while disabled", RegStatus);
		endTest();

		startTest("ordered delivery");
		writeReg(RegCtrl, 32'd1);
		repeat (6) sendCode(1'b0, 1'b0);
		readCheck("status", RegStatus);
		repeat (6) readCheck("data", RegData);
		readCheck("status drained", RegStatus);
		readCheck("data empty", RegData);
		endTest();

		startTest("frame errors");
		sendCode(1'b1, 1'b0);
		sendCode(1'b0, 1'b1);
		sendCode(1'b0, 1'b0);
		readCheck("status", RegStatus);
		readCheck("data", RegData);
		writeReg(RegStatus, 32'd1 << StatFrameErr);
		readCheck("status cleared", RegStatus);
		endTest();

		startTest("overflow");
		repeat (10) sendCode(1'b0, 1'b0);
		readCheck("status", RegStatus);
		repeat (8) readCheck("data", RegData);
		readCheck("status drained", RegStatus);
		writeReg(RegStatus, 32'd1 << StatOverflow);
		readCheck("status cleared", RegStatus);
		endTest();

		startTest("flush and bus errors");
		repeat (3) sendCode(1'b0, 1'b0);
		readCheck("status", RegStatus);
		writeReg(RegCtrl, 32'd0);
		readCheck("status flushed", RegStatus);
		readCheck("ctrl", RegCtrl);
		readCheck("data flushed", RegData);
		readCheck("bad offset", 12'h00C);
		writeReg(RegData, 32'h55);
		endTest();

		$display("Tests run %0d, failed %0d, mismatches %0d", testsRun, testsFailed, errCount);
		if (errCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- ps2KbTop.f
ps2KbPkg.sv
ps2FrameRx.sv
scanFifo.sv
ps2ApbRegs.sv
ps2KbTop.sv
ps2KbdModel.sv
ps2KbTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the PS/2 keyboard receiver testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f ps2KbTop.f --top-module ps2KbTb -o ps2KbSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/ps2KbSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -qx "Done: no errors"; then
	exit 0
fi
exit 1
